// File: design/serial_link_pkg.sv
`default_nettype none

package serial_link_pkg;

  //////////////////////////////////////////////////
  // Link parameters
  //////////////////////////////////////////////////

  parameter int NumLanes   = 8;
  // Must fit the 3-bit credit field of the header
  parameter int NumCredits = 4;
  parameter int FrameBits  = 72;
  parameter int FrameBeats = FrameBits / NumLanes;

  //////////////////////////////////////////////////
  // Flit and frame types
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    VcNarrowReq = 2'd0,
    VcNarrowRsp = 2'd1,
    VcWide      = 2'd2,
    VcNone      = 2'd3
  } vc_e;

  typedef struct packed {
    logic [7:0]  id;
    logic [23:0] rsvd;
    logic [31:0] data;
  } narrow_flit_t;

  typedef struct packed {
    logic [63:0] data;
  } wide_flit_t;

  // Same payload word, read by the header's channel kind
  typedef union packed {
    narrow_flit_t narrow;
    wide_flit_t   wide;
  } link_data_u;

  typedef struct packed {
    vc_e        vc;
    logic [2:0] credits;
    logic [2:0] rsvd;
  } link_hdr_t;

  typedef struct packed {
    link_hdr_t  hdr;
    link_data_u data;
  } link_frame_t;

  typedef struct packed {
    logic         valid;
    narrow_flit_t flit;
  } narrow_chan_t;

  typedef struct packed {
    logic       valid;
    wide_flit_t flit;
  } wide_chan_t;

endpackage

`default_nettype wire

// File: design/floo_link_arbiter.sv
`default_nettype none

module floo_link_arbiter import serial_link_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  // Bit index matches the vc_e encoding
  input  logic [2:0] req_i,
  input  logic       accept_i,
  output vc_e        grant_o
);

  logic [1:0] ptr_q;

  // Search from the pointer, lowest offset wins
  always_comb begin
    logic [1:0] idx;
    grant_o = VcNone;
    for (int i = 2; i >= 0; i--) begin
      idx = 2'((int'(ptr_q) + i) % 3);
      if (req_i[idx]) begin
        grant_o = vc_e'(idx);
      end
    end
  end

  // Next search starts just past the granted channel
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= 2'd0;
    end else if (accept_i && grant_o != VcNone) begin
      ptr_q <= (grant_o == VcWide) ? 2'd0 : 2'(grant_o) + 2'd1;
    end
  end

endmodule

`default_nettype wire

// File: design/floo_link_bridge.sv
`default_nettype none

module floo_link_bridge import serial_link_pkg::*; (
  input  logic         clk_i,
  input  logic         reset_i,
  input  narrow_chan_t narrow_req_i,
  input  narrow_chan_t narrow_rsp_i,
  input  wide_chan_t   wide_i,
  output logic         narrow_req_ready_o,
  output logic         narrow_rsp_ready_o,
  output logic         wide_ready_o,
  output narrow_chan_t narrow_req_o,
  output narrow_chan_t narrow_rsp_o,
  output wide_chan_t   wide_o,
  input  logic         narrow_req_ready_i,
  input  logic         narrow_rsp_ready_i,
  input  logic         wide_ready_i,
  output link_frame_t  tx_frame_o,
  output logic         tx_valid_o,
  input  logic         tx_ready_i,
  input  link_frame_t  rx_frame_i,
  input  logic         rx_valid_i,
  output logic         rx_ready_o
);

  vc_e grant;

  floo_link_arbiter i_floo_link_arbiter (
    .clk_i    ( clk_i                                              ),
    .reset_i  ( reset_i                                            ),
    .req_i    ( {wide_i.valid, narrow_rsp_i.valid, narrow_req_i.valid} ),
    .accept_i ( tx_valid_o && tx_ready_i                           ),
    .grant_o  ( grant                                              )
  );

  //////////////////////////////////////////////////
  // Send side
  //////////////////////////////////////////////////

  assign tx_valid_o = (grant != VcNone);

  // Credit field is left to the data link
  always_comb begin
    tx_frame_o = '0;
    tx_frame_o.hdr.vc = grant;
    case (grant)
      VcNarrowReq: tx_frame_o.data.narrow = narrow_req_i.flit;
      VcNarrowRsp: tx_frame_o.data.narrow = narrow_rsp_i.flit;
      VcWide:      tx_frame_o.data.wide   = wide_i.flit;
      default:     tx_frame_o.data        = '0;
    endcase
  end

  assign narrow_req_ready_o = tx_ready_i && (grant == VcNarrowReq);
  assign narrow_rsp_ready_o = tx_ready_i && (grant == VcNarrowRsp);
  assign wide_ready_o       = tx_ready_i && (grant == VcWide);

  //////////////////////////////////////////////////
  // Receive side
  //////////////////////////////////////////////////

  assign narrow_req_o.valid = rx_valid_i && (rx_frame_i.hdr.vc == VcNarrowReq);
  assign narrow_req_o.flit  = rx_frame_i.data.narrow;
  assign narrow_rsp_o.valid = rx_valid_i && (rx_frame_i.hdr.vc == VcNarrowRsp);
  assign narrow_rsp_o.flit  = rx_frame_i.data.narrow;
  assign wide_o.valid       = rx_valid_i && (rx_frame_i.hdr.vc == VcWide);
  assign wide_o.flit        = rx_frame_i.data.wide;

  always_comb begin
    case (rx_frame_i.hdr.vc)
      VcNarrowReq: rx_ready_o = narrow_req_ready_i;
      VcNarrowRsp: rx_ready_o = narrow_rsp_ready_i;
      VcWide:      rx_ready_o = wide_ready_i;
      // No owner, just drain it
      default:     rx_ready_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: design/serial_link_rx_fifo.sv
`default_nettype none

module serial_link_rx_fifo import serial_link_pkg::*; #(
  parameter int Depth = NumCredits
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        push_i,
  input  link_frame_t data_i,
  output logic        valid_o,
  output link_frame_t data_o,
  input  logic        pop_i,
  output logic        full_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  link_frame_t     mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push;
  logic            do_pop;

  // Wraps at Depth, which need not be a power of two
  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + PtrW'(1);
  endfunction

  assign full_o  = (count_q == CntW'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

endmodule

`default_nettype wire

// File: design/serial_link_data_link.sv
`default_nettype none

module serial_link_data_link import serial_link_pkg::*; #(
  parameter int NumCredits = serial_link_pkg::NumCredits
) (
  input  logic        clk_i,
  input  logic        reset_i,
  // From and to the bridge
  input  link_frame_t tx_frame_i,
  input  logic        tx_valid_i,
  output logic        tx_ready_o,
  output link_frame_t rx_frame_o,
  output logic        rx_valid_o,
  input  logic        rx_ready_i,
  // From and to the physical layer
  output link_frame_t phy_frame_o,
  output logic        phy_valid_o,
  input  logic        phy_ready_i,
  input  link_frame_t rx_phy_frame_i,
  input  logic        rx_phy_valid_i
);

  logic [2:0]  credit_cnt_q, credit_cnt_d;
  logic [2:0]  pending_q, pending_d;
  logic        has_credit;
  logic        send_payload;
  logic        send_credit;
  logic        phy_fire;
  logic        rx_push;
  logic        rx_pop;
  logic        rx_full;
  link_frame_t rx_payload;

  //////////////////////////////////////////////////
  // Send side
  //////////////////////////////////////////////////

  assign has_credit   = (credit_cnt_q != 3'd0);
  assign tx_ready_o   = phy_ready_i && has_credit;
  assign send_payload = tx_valid_i && has_credit;
  // Credit-only frame when nothing else can carry the return
  assign send_credit  = !send_payload && (pending_q != 3'd0);
  assign phy_valid_o  = send_payload || send_credit;
  assign phy_fire     = phy_valid_o && phy_ready_i;

  always_comb begin
    phy_frame_o = tx_frame_i;
    phy_frame_o.hdr.credits = pending_q;
    phy_frame_o.hdr.rsvd = '0;
    if (!send_payload) begin
      phy_frame_o.hdr.vc = VcNone;
      phy_frame_o.data = '0;
    end
  end

  //////////////////////////////////////////////////
  // Credit counting
  //////////////////////////////////////////////////

  always_comb begin
    credit_cnt_d = credit_cnt_q;
    if (rx_phy_valid_i) begin
      credit_cnt_d = credit_cnt_d + rx_phy_frame_i.hdr.credits;
    end
    if (phy_fire && send_payload) begin
      credit_cnt_d = credit_cnt_d - 3'd1;
    end
  end

  // Everything pending goes out with the frame just accepted
  always_comb begin
    pending_d = pending_q;
    if (phy_fire) begin
      pending_d = 3'd0;
    end
    if (rx_pop) begin
      pending_d = pending_d + 3'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_cnt_q <= 3'(NumCredits);
      pending_q    <= 3'd0;
    end else begin
      credit_cnt_q <= credit_cnt_d;
      pending_q    <= pending_d;
    end
  end

  //////////////////////////////////////////////////
  // Receive side
  //////////////////////////////////////////////////

  always_comb begin
    rx_payload = rx_phy_frame_i;
    rx_payload.hdr.credits = '0;
  end

  assign rx_push = rx_phy_valid_i && (rx_phy_frame_i.hdr.vc != VcNone);
  assign rx_pop  = rx_valid_o && rx_ready_i;

  serial_link_rx_fifo #(
    .Depth ( NumCredits )
  ) i_serial_link_rx_fifo (
    .clk_i   ( clk_i      ),
    .reset_i ( reset_i    ),
    .push_i  ( rx_push    ),
    .data_i  ( rx_payload ),
    .valid_o ( rx_valid_o ),
    .data_o  ( rx_frame_o ),
    .pop_i   ( rx_pop     ),
    .full_o  ( rx_full    )
  );

endmodule

`default_nettype wire

// File: design/serial_link_phy_tx.sv
`default_nettype none

module serial_link_phy_tx import serial_link_pkg::*; #(
  parameter int NumLanes = serial_link_pkg::NumLanes
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  link_frame_t         frame_i,
  input  logic                valid_i,
  output logic                ready_o,
  output logic [NumLanes-1:0] phy_data_o,
  output logic                phy_clk_o
);

  localparam int NumBeats = FrameBits / NumLanes;
  localparam int CntW     = $clog2(NumBeats + 1);

  logic [FrameBits-1:0] shift_q;
  logic [CntW-1:0]      beat_cnt_q;
  logic                 busy_q;

  assign ready_o = !busy_q;

  // First beat leaves on the load cycle, the rest from the shift register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q     <= 1'b0;
      beat_cnt_q <= '0;
      phy_data_o <= '0;
      phy_clk_o  <= 1'b0;
    end else if (valid_i && ready_o) begin
      phy_data_o <= frame_i[NumLanes-1:0];
      phy_clk_o  <= ~phy_clk_o;
      beat_cnt_q <= CntW'(1);
      busy_q     <= (NumBeats > 1);
    end else if (busy_q) begin
      phy_data_o <= shift_q[NumLanes-1:0];
      phy_clk_o  <= ~phy_clk_o;
      beat_cnt_q <= beat_cnt_q + CntW'(1);
      if (beat_cnt_q == CntW'(NumBeats - 1)) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      shift_q <= frame_i >> NumLanes;
    end else if (busy_q) begin
      shift_q <= shift_q >> NumLanes;
    end
  end

endmodule

`default_nettype wire

// File: design/serial_link_phy_rx.sv
`default_nettype none

module serial_link_phy_rx import serial_link_pkg::*; #(
  parameter int NumLanes = serial_link_pkg::NumLanes
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [NumLanes-1:0] phy_data_i,
  input  logic                phy_clk_i,
  output link_frame_t         frame_o,
  output logic                valid_o
);

  localparam int NumBeats = FrameBits / NumLanes;
  localparam int CntW     = $clog2(NumBeats + 1);

  logic [FrameBits-1:0] shift_q;
  logic [CntW-1:0]      beat_cnt_q;
  logic                 strobe_q;
  logic                 beat;

  // Any strobe edge marks a new beat
  assign beat    = phy_clk_i ^ strobe_q;
  assign frame_o = link_frame_t'(shift_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      strobe_q   <= 1'b0;
      beat_cnt_q <= '0;
      valid_o    <= 1'b0;
    end else begin
      strobe_q <= phy_clk_i;
      valid_o  <= 1'b0;
      if (beat) begin
        if (beat_cnt_q == CntW'(NumBeats - 1)) begin
          beat_cnt_q <= '0;
          valid_o    <= 1'b1;
        end else begin
          beat_cnt_q <= beat_cnt_q + CntW'(1);
        end
      end
    end
  end

  // Lowest beat arrives first and ends up at the bottom
  always_ff @(posedge clk_i) begin
    if (beat) begin
      shift_q <= {phy_data_i, shift_q[FrameBits-1:NumLanes]};
    end
  end

endmodule

`default_nettype wire

// File: design/floo_serial_link.sv
`default_nettype none

module floo_serial_link import serial_link_pkg::*; #(
  parameter int NumLanes   = serial_link_pkg::NumLanes,
  parameter int NumCredits = serial_link_pkg::NumCredits
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // On-chip channels into the link
  input  narrow_chan_t        narrow_req_i,
  input  narrow_chan_t        narrow_rsp_i,
  input  wide_chan_t          wide_i,
  output logic                narrow_req_ready_o,
  output logic                narrow_rsp_ready_o,
  output logic                wide_ready_o,
  // On-chip channels out of the link
  output narrow_chan_t        narrow_req_o,
  output narrow_chan_t        narrow_rsp_o,
  output wide_chan_t          wide_o,
  input  logic                narrow_req_ready_i,
  input  logic                narrow_rsp_ready_i,
  input  logic                wide_ready_i,
  // Off-chip pins
  output logic [NumLanes-1:0] phy_data_o,
  output logic                phy_clk_o,
  input  logic [NumLanes-1:0] phy_data_i,
  input  logic                phy_clk_i
);

  link_frame_t tx_frame;
  logic        tx_valid;
  logic        tx_ready;
  link_frame_t rx_frame;
  logic        rx_valid;
  logic        rx_ready;
  link_frame_t phy_frame;
  logic        phy_valid;
  logic        phy_ready;
  link_frame_t rx_phy_frame;
  logic        rx_phy_valid;

  //////////////////////////////////////////////////
  // Network bridge
  //////////////////////////////////////////////////

  floo_link_bridge i_floo_link_bridge (
    .clk_i              ( clk_i              ),
    .reset_i            ( reset_i            ),
    .narrow_req_i       ( narrow_req_i       ),
    .narrow_rsp_i       ( narrow_rsp_i       ),
    .wide_i             ( wide_i             ),
    .narrow_req_ready_o ( narrow_req_ready_o ),
    .narrow_rsp_ready_o ( narrow_rsp_ready_o ),
    .wide_ready_o       ( wide_ready_o       ),
    .narrow_req_o       ( narrow_req_o       ),
    .narrow_rsp_o       ( narrow_rsp_o       ),
    .wide_o             ( wide_o             ),
    .narrow_req_ready_i ( narrow_req_ready_i ),
    .narrow_rsp_ready_i ( narrow_rsp_ready_i ),
    .wide_ready_i       ( wide_ready_i       ),
    .tx_frame_o         ( tx_frame           ),
    .tx_valid_o         ( tx_valid           ),
    .tx_ready_i         ( tx_ready           ),
    .rx_frame_i         ( rx_frame           ),
    .rx_valid_i         ( rx_valid           ),
    .rx_ready_o         ( rx_ready           )
  );

  //////////////////////////////////////////////////
  // Data link layer
  //////////////////////////////////////////////////

  serial_link_data_link #(
    .NumCredits ( NumCredits )
  ) i_serial_link_data_link (
    .clk_i          ( clk_i        ),
    .reset_i        ( reset_i      ),
    .tx_frame_i     ( tx_frame     ),
    .tx_valid_i     ( tx_valid     ),
    .tx_ready_o     ( tx_ready     ),
    .rx_frame_o     ( rx_frame     ),
    .rx_valid_o     ( rx_valid     ),
    .rx_ready_i     ( rx_ready     ),
    .phy_frame_o    ( phy_frame    ),
    .phy_valid_o    ( phy_valid    ),
    .phy_ready_i    ( phy_ready    ),
    .rx_phy_frame_i ( rx_phy_frame ),
    .rx_phy_valid_i ( rx_phy_valid )
  );

  //////////////////////////////////////////////////
  // Physical layer
  //////////////////////////////////////////////////

  serial_link_phy_tx #(
    .NumLanes ( NumLanes )
  ) i_serial_link_phy_tx (
    .clk_i      ( clk_i      ),
    .reset_i    ( reset_i    ),
    .frame_i    ( phy_frame  ),
    .valid_i    ( phy_valid  ),
    .ready_o    ( phy_ready  ),
    .phy_data_o ( phy_data_o ),
    .phy_clk_o  ( phy_clk_o  )
  );

  serial_link_phy_rx #(
    .NumLanes ( NumLanes )
  ) i_serial_link_phy_rx (
    .clk_i      ( clk_i        ),
    .reset_i    ( reset_i      ),
    .phy_data_i ( phy_data_i   ),
    .phy_clk_i  ( phy_clk_i    ),
    .frame_o    ( rx_phy_frame ),
    .valid_o    ( rx_phy_valid )
  );

endmodule

`default_nettype wire

// File: test/tb_link_checker.sv
`default_nettype none

module tb_link_checker import serial_link_pkg::*; #(
  parameter int NumLanes = serial_link_pkg::NumLanes
) (
  input  logic                clk_i,
  input  logic                reset_i,
  // Channels into the DUT
  input  narrow_chan_t        in_narrow_req_i,
  input  narrow_chan_t        in_narrow_rsp_i,
  input  wide_chan_t          in_wide_i,
  input  logic                in_narrow_req_ready_i,
  input  logic                in_narrow_rsp_ready_i,
  input  logic                in_wide_ready_i,
  // Channels out of the DUT
  input  narrow_chan_t        out_narrow_req_i,
  input  narrow_chan_t        out_narrow_rsp_i,
  input  wide_chan_t          out_wide_i,
  input  logic                out_narrow_req_ready_i,
  input  logic                out_narrow_rsp_ready_i,
  input  logic                out_wide_ready_i,
  input  logic [NumLanes-1:0] phy_data_i,
  input  logic                phy_clk_i,
  output int                  error_count_o,
  output int                  pending_o
);

  timeunit 1ns;
  timeprecision 100ps;

  narrow_flit_t req_queue [$];
  narrow_flit_t rsp_queue [$];
  wide_flit_t   wide_queue [$];
  logic         reset_q;
  int           errors = 0;
  int           pending = 0;

  assign error_count_o = errors;
  assign pending_o     = pending;

  task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    $display("CHECK FAILED at %0d ns: %s expected %h, actual %h",
             $time, name, expected, actual);
    errors++;
  endtask

  task automatic report_extra(string name);
    $display("At %0d ns %s delivered a flit that was never sent", $time, name);
    errors++;
  endtask

  task automatic compare_narrow(string name, narrow_flit_t expected, narrow_flit_t actual);
    if (actual.id !== expected.id) begin
      report_mismatch({name, ".flit.id"}, 64'(expected.id), 64'(actual.id));
    end
    if (actual.rsvd !== expected.rsvd) begin
      report_mismatch({name, ".flit.rsvd"}, 64'(expected.rsvd), 64'(actual.rsvd));
    end
    if (actual.data !== expected.data) begin
      report_mismatch({name, ".flit.data"}, 64'(expected.data), 64'(actual.data));
    end
  endtask

  // Outputs just after reset release
  task automatic check_reset_state();
    if (out_narrow_req_i.valid !== 1'b0) begin
      report_mismatch("narrow_req_o.valid", 64'(0), 64'(out_narrow_req_i.valid));
    end
    if (out_narrow_rsp_i.valid !== 1'b0) begin
      report_mismatch("narrow_rsp_o.valid", 64'(0), 64'(out_narrow_rsp_i.valid));
    end
    if (out_wide_i.valid !== 1'b0) begin
      report_mismatch("wide_o.valid", 64'(0), 64'(out_wide_i.valid));
    end
    if (phy_clk_i !== 1'b0) begin
      report_mismatch("phy_clk_o", 64'(0), 64'(phy_clk_i));
    end
    if (phy_data_i !== '0) begin
      report_mismatch("phy_data_o", 64'(0), 64'(phy_data_i));
    end
  endtask

  always @(posedge clk_i) begin
    reset_q <= reset_i;
    if (reset_q && !reset_i) begin
      check_reset_state();
    end
    if (!reset_i) begin
      //////////////////////////////////////////////////
      // Record accepted inputs
      //////////////////////////////////////////////////
      if (in_narrow_req_i.valid && in_narrow_req_ready_i) begin
        req_queue.push_back(in_narrow_req_i.flit);
      end
      if (in_narrow_rsp_i.valid && in_narrow_rsp_ready_i) begin
        rsp_queue.push_back(in_narrow_rsp_i.flit);
      end
      if (in_wide_i.valid && in_wide_ready_i) begin
        wide_queue.push_back(in_wide_i.flit);
      end
      //////////////////////////////////////////////////
      // Compare delivered outputs
      //////////////////////////////////////////////////
      if (out_narrow_req_i.valid && out_narrow_req_ready_i) begin
        if (req_queue.size() == 0) begin
          report_extra("narrow_req_o");
        end else begin
          compare_narrow("narrow_req_o", req_queue.pop_front(), out_narrow_req_i.flit);
        end
      end
      if (out_narrow_rsp_i.valid && out_narrow_rsp_ready_i) begin
        if (rsp_queue.size() == 0) begin
          report_extra("narrow_rsp_o");
        end else begin
          compare_narrow("narrow_rsp_o", rsp_queue.pop_front(), out_narrow_rsp_i.flit);
        end
      end
      if (out_wide_i.valid && out_wide_ready_i) begin
        if (wide_queue.size() == 0) begin
          report_extra("wide_o");
        end else if (out_wide_i.flit !== wide_queue[0]) begin
          report_mismatch("wide_o.flit.data", wide_queue.pop_front(), out_wide_i.flit);
        end else begin
          void'(wide_queue.pop_front());
        end
      end
    end
    pending = req_queue.size() + rsp_queue.size() + wide_queue.size();
  end

endmodule

`default_nettype wire

// File: test/tb_link_assert.sv
`default_nettype none

module tb_link_assert import serial_link_pkg::*; #(
  parameter int NumCredits = serial_link_pkg::NumCredits
) (
  input logic       clk_i,
  input logic       reset_i,
  input logic [2:0] credit_cnt_i,
  input logic       rx_push_i,
  input logic       rx_full_i,
  input logic       phy_valid_i,
  input logic       phy_ready_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int failures = 0;

  // Returned credits can never exceed what the receiver can hold
  credit_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_cnt_i <= 3'(NumCredits))
    else begin
      failures++;
      $error("Credit count is above the receive buffer depth");
    end

  no_push_when_full: assert property (@(posedge clk_i) disable iff (reset_i)
    !(rx_push_i && rx_full_i))
    else begin
      failures++;
      $error("Receive buffer was pushed while full");
    end

  phy_valid_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    phy_valid_i && !phy_ready_i |=> phy_valid_i)
    else begin
      failures++;
      $error("Frame valid to the transmitter dropped before it was accepted");
    end

endmodule

`default_nettype wire

// File: test/tb_floo_serial_link.sv
`default_nettype none

module tb_floo_serial_link import serial_link_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WaitCycles  = 200;
  localparam int DrainCycles = 2000;
  localparam int HoldEntries = 8;
  localparam int LongEntries = 48;

  typedef struct packed {
    vc_e         kind;
    logic [7:0]  id;
    logic [63:0] data;
  } stim_t;

  typedef enum logic [1:0] {
    ReadyHigh,
    ReadyLow,
    ReadyRandom
  } ready_mode_e;

  // Interleaved kinds with wide data using all 64 bits
  localparam stim_t BaseTable [10] = '{
    '{VcNarrowReq, 8'h11, 64'h0000_0000_cafe_0001},
    '{VcWide,      8'h00, 64'h0123_4567_89ab_cdef},
    '{VcNarrowRsp, 8'h22, 64'h0000_0000_beef_0002},
    '{VcNarrowReq, 8'h33, 64'h0000_0000_cafe_0003},
    '{VcNarrowReq, 8'hff, 64'h0000_0000_ffff_ffff},
    '{VcWide,      8'h00, 64'hfedc_ba98_7654_3210},
    '{VcNarrowRsp, 8'h00, 64'h0000_0000_0000_0000},
    '{VcWide,      8'h00, 64'h8000_0000_0000_0001},
    '{VcNarrowRsp, 8'h5a, 64'h0000_0000_a5a5_5a5a},
    '{VcNarrowReq, 8'h80, 64'h0000_0000_1234_5678}
  };

  logic                clk = 1'b0;
  logic                reset;
  narrow_chan_t        narrow_req_in;
  narrow_chan_t        narrow_rsp_in;
  wide_chan_t          wide_in;
  logic                narrow_req_ready;
  logic                narrow_rsp_ready;
  logic                wide_ready;
  narrow_chan_t        narrow_req_out;
  narrow_chan_t        narrow_rsp_out;
  wide_chan_t          wide_out;
  logic                narrow_req_sink_ready;
  logic                narrow_rsp_sink_ready;
  logic                wide_sink_ready;
  logic [NumLanes-1:0] phy_data;
  logic                phy_clk;
  ready_mode_e         ready_mode = ReadyHigh;
  int                  check_errors;
  int                  pending;
  int                  flow_errors = 0;

  floo_serial_link i_floo_serial_link (
    .clk_i              ( clk                   ),
    .reset_i            ( reset                 ),
    .narrow_req_i       ( narrow_req_in         ),
    .narrow_rsp_i       ( narrow_rsp_in         ),
    .wide_i             ( wide_in               ),
    .narrow_req_ready_o ( narrow_req_ready      ),
    .narrow_rsp_ready_o ( narrow_rsp_ready      ),
    .wide_ready_o       ( wide_ready            ),
    .narrow_req_o       ( narrow_req_out        ),
    .narrow_rsp_o       ( narrow_rsp_out        ),
    .wide_o             ( wide_out              ),
    .narrow_req_ready_i ( narrow_req_sink_ready ),
    .narrow_rsp_ready_i ( narrow_rsp_sink_ready ),
    .wide_ready_i       ( wide_sink_ready       ),
    // The link talks to itself through the loopback
    .phy_data_o         ( phy_data              ),
    .phy_clk_o          ( phy_clk               ),
    .phy_data_i         ( phy_data              ),
    .phy_clk_i          ( phy_clk               )
  );

  tb_link_checker i_tb_link_checker (
    .clk_i                  ( clk                   ),
    .reset_i                ( reset                 ),
    .in_narrow_req_i        ( narrow_req_in         ),
    .in_narrow_rsp_i        ( narrow_rsp_in         ),
    .in_wide_i              ( wide_in               ),
    .in_narrow_req_ready_i  ( narrow_req_ready      ),
    .in_narrow_rsp_ready_i  ( narrow_rsp_ready      ),
    .in_wide_ready_i        ( wide_ready            ),
    .out_narrow_req_i       ( narrow_req_out        ),
    .out_narrow_rsp_i       ( narrow_rsp_out        ),
    .out_wide_i             ( wide_out              ),
    .out_narrow_req_ready_i ( narrow_req_sink_ready ),
    .out_narrow_rsp_ready_i ( narrow_rsp_sink_ready ),
    .out_wide_ready_i       ( wide_sink_ready       ),
    .phy_data_i             ( phy_data              ),
    .phy_clk_i              ( phy_clk               ),
    .error_count_o          ( check_errors          ),
    .pending_o              ( pending               )
  );

  bind serial_link_data_link tb_link_assert #(
    .NumCredits ( NumCredits )
  ) i_tb_link_assert (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .credit_cnt_i ( credit_cnt_q ),
    .rx_push_i    ( rx_push      ),
    .rx_full_i    ( rx_full      ),
    .phy_valid_i  ( phy_valid_o  ),
    .phy_ready_i  ( phy_ready_i  )
  );

  initial begin
    forever #50 clk = ~clk;
  end

  // Output readies change on the falling edge only
  initial begin
    void'($urandom(32'hfff2));
    narrow_req_sink_ready = 1'b1;
    narrow_rsp_sink_ready = 1'b1;
    wide_sink_ready       = 1'b1;
    forever begin
      @(negedge clk);
      case (ready_mode)
        ReadyLow: begin
          {narrow_req_sink_ready, narrow_rsp_sink_ready, wide_sink_ready} = 3'b000;
        end
        ReadyRandom: begin
          {narrow_req_sink_ready, narrow_rsp_sink_ready, wide_sink_ready} =
            3'($urandom_range(7, 0));
        end
        default: begin
          {narrow_req_sink_ready, narrow_rsp_sink_ready, wide_sink_ready} = 3'b111;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  function automatic stim_t make_entry(int base, int idx);
    stim_t e;
    e.kind = vc_e'(2'((idx + idx / 4) % 3));
    e.id   = 8'(base + idx);
    e.data = {32'(base * 1000 + idx), 32'hc0de_0000 ^ 32'(idx * 37)};
    // Narrow flits carry only 32 data bits
    if (e.kind != VcWide) begin
      e.data[63:32] = '0;
    end
    return e;
  endfunction

  function automatic bit handshake(vc_e kind);
    case (kind)
      VcNarrowReq: return narrow_req_in.valid && narrow_req_ready;
      VcNarrowRsp: return narrow_rsp_in.valid && narrow_rsp_ready;
      VcWide:      return wide_in.valid && wide_ready;
      default:     return 1'b0;
    endcase
  endfunction

  task automatic clear_inputs();
    narrow_req_in = '0;
    narrow_rsp_in = '0;
    wide_in       = '0;
  endtask

  task automatic apply_entry(stim_t entry);
    clear_inputs();
    case (entry.kind)
      VcNarrowReq: narrow_req_in = '{1'b1, '{entry.id, 24'h0, entry.data[31:0]}};
      VcNarrowRsp: narrow_rsp_in = '{1'b1, '{entry.id, 24'h0, entry.data[31:0]}};
      default:     wide_in       = '{1'b1, '{entry.data}};
    endcase
  endtask

  task automatic wait_accept(vc_e kind, output bit accepted);
    accepted = 1'b0;
    for (int n = 0; n < WaitCycles && !accepted; n++) begin
      @(posedge clk);
      accepted = handshake(kind);
    end
  endtask

  task automatic send_entry(stim_t entry, output bit accepted);
    @(negedge clk);
    apply_entry(entry);
    wait_accept(entry.kind, accepted);
  endtask

  task automatic send_or_report(stim_t entry);
    bit ok;
    send_entry(entry, ok);
    if (!ok) begin
      $display("At %0d ns the %s flit with id %h was not accepted in %0d cycles",
               $time, entry.kind.name(), entry.id, WaitCycles);
      flow_errors++;
    end
  endtask

  task automatic drain_all();
    bit drained;
    drained = 1'b0;
    @(negedge clk);
    clear_inputs();
    for (int n = 0; n < DrainCycles && !drained; n++) begin
      @(negedge clk);
      drained = (pending == 0);
    end
    if (!drained) begin
      $display("At %0d ns %0d flits were still missing after %0d cycles",
               $time, pending, DrainCycles);
      flow_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    stim_t stalled_entry;
    int    accepted_cnt;
    int    assert_errors;
    bit    ok;
    bit    stalled;

    reset = 1'b1;
    clear_inputs();
    repeat (5) @(negedge clk);
    reset = 1'b0;

    // Mixed kinds with all outputs ready
    foreach (BaseTable[i]) begin
      send_or_report(BaseTable[i]);
    end
    drain_all();

    // The sender runs out of credits while the outputs are blocked
    ready_mode   <= ReadyLow;
    accepted_cnt = 0;
    stalled      = 1'b0;
    for (int i = 0; i < HoldEntries && !stalled; i++) begin
      stalled_entry = make_entry(64, i);
      send_entry(stalled_entry, ok);
      if (ok) begin
        accepted_cnt++;
      end else begin
        stalled = 1'b1;
      end
    end
    if (!stalled || accepted_cnt < NumCredits || accepted_cnt > NumCredits + 2) begin
      $display("With blocked outputs the inputs accepted %0d flits, allowed %0d to %0d",
               accepted_cnt, NumCredits, NumCredits + 2);
      flow_errors++;
    end
    ready_mode <= ReadyHigh;
    if (stalled) begin
      wait_accept(stalled_entry.kind, ok);
      if (!ok) begin
        $display("The held %s flit was not accepted after the outputs were released",
                 stalled_entry.kind.name());
        flow_errors++;
      end
    end
    drain_all();

    // Long run against random back-pressure
    ready_mode <= ReadyRandom;
    for (int i = 0; i < LongEntries; i++) begin
      send_or_report(make_entry(128, i));
    end
    ready_mode <= ReadyHigh;
    drain_all();

    assert_errors = i_floo_serial_link.i_serial_link_data_link.i_tb_link_assert.failures;
    $display("Error count: %0d from checks, %0d from flow and timeouts, %0d from assertions",
             check_errors, flow_errors, assert_errors);
    if (check_errors + flow_errors + assert_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: floo_serial_link.f
design/serial_link_pkg.sv
design/floo_link_arbiter.sv
design/floo_link_bridge.sv
design/serial_link_rx_fifo.sv
design/serial_link_data_link.sv
design/serial_link_phy_tx.sv
design/serial_link_phy_rx.sv
design/floo_serial_link.sv
test/tb_link_checker.sv
test/tb_link_assert.sv
test/tb_floo_serial_link.sv

// File: run.sh
#!/bin/sh
# Build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_floo_serial_link --Mdir "$BUILD_DIR" \
  -f floo_serial_link.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_floo_serial_link" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
